// ==== compile.f ====
+incdir+tb
hdl/i2c_pkg.sv
hdl/regmap_pkg.sv
hdl/i2c_bus_sampler.sv
hdl/i2c_slave_ctrl.sv
hdl/i2c_reg_file.sv
hdl/i2c_slave_top.sv
tb/tb_i2c_slave.sv

// ==== Makefile ====
# Verilator simulation of the I2C target testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fails on a failing run"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -f compile.f --top-module tb_i2c_slave \
		-Mdir obj_dir -o sim
	./obj_dir/sim | tee sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb/i2c_master_tasks.svh ====
//********************
// bit-level I2C controller, SCL half period is 60 sys_clk cycles
// uses sys_clk, scl_m, sda_m and sda_bus of the including module
//********************
`ifndef I2C_MASTER_TASKS_SVH
`define I2C_MASTER_TASKS_SVH

localparam int HALF_CYC     = 60;
localparam int QTR_CYC      = 30;
localparam int FREE_TIMEOUT = 2000; // cycles allowed for SDA to go free

// step n clock edges, land 10 ns after the last one
task automatic wait_clks(input int n);
	repeat (n) @(posedge sys_clk);
	#10;
endtask

// one SCL period, mid is SDA at the middle of SCL high
task automatic clock_bit(input logic val, output logic mid, output logic any_low);
	any_low = 1'b0;
	mid     = 1'b1;
	wait_clks(QTR_CYC);
	sda_m = val; // data changes only while SCL is low
	for (int i = 0; i < QTR_CYC; i++) begin
		wait_clks(1);
		any_low |= !sda_bus;
	end
	scl_m = 1'b1;
	for (int i = 0; i < HALF_CYC; i++) begin
		wait_clks(1);
		any_low |= !sda_bus;
		if (i == QTR_CYC) begin
			mid = sda_bus;
		end
	end
	scl_m = 1'b0;
endtask

// START, or repeated START when SCL is low
task automatic bus_start;
	int n;
	n = 0;
	if (!scl_m) begin
		wait_clks(QTR_CYC);
		sda_m = 1'b1;
		wait_clks(QTR_CYC);
		scl_m = 1'b1;
	end
	while (!sda_bus && n < FREE_TIMEOUT) begin
		wait_clks(1);
		n++;
	end
	if (n >= FREE_TIMEOUT) begin
		$display("timeout: SDA stayed low, no START could be sent");
		$display("TEST FAIL");
		$finish;
	end else begin
		wait_clks(HALF_CYC);
		sda_m = 1'b0;
		wait_clks(HALF_CYC);
		scl_m = 1'b0;
	end
endtask

task automatic bus_stop;
	wait_clks(QTR_CYC);
	sda_m = 1'b0;
	wait_clks(QTR_CYC);
	scl_m = 1'b1;
	wait_clks(HALF_CYC);
	sda_m = 1'b1;
	wait_clks(2 * HALF_CYC); // bus free time
endtask

// pulled is any low level in the ACK slot after SDA release
task automatic write_byte(input logic [7:0] data, output logic ack, output logic pulled);
	logic mid;
	logic low;
	for (int i = 7; i >= 0; i--) begin
		clock_bit(data[i], mid, low);
	end
	clock_bit(1'b1, mid, pulled);
	ack = !mid;
endtask

task automatic read_byte(input logic nack, output logic [7:0] data);
	logic mid;
	logic low;
	for (int i = 7; i >= 0; i--) begin
		clock_bit(1'b1, mid, low);
		data[i] = mid;
	end
	clock_bit(nack, mid, low);
endtask

`endif

// ==== tb/tb_i2c_slave.sv ====
//********************
// DUT at default parameters, SCL about 83 kHz
// SDA is the wired-AND of the bus controller model and the DUT
//********************
module tb_i2c_slave
	import i2c_pkg::*;
	import regmap_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		logic       is_ack;
		reg_addr_t  addr;
		logic [7:0] exp;
		logic [7:0] got;
	} check_t;

	logic       sys_clk;
	logic       rst_n;
	logic       scl_m;
	logic       sda_m;
	logic       sda_bus;
	logic       sda_oe;
	logic       sda_out;
	logic [6:0] mdl_dev;
	logic [7:0] mdl_rw [8];
	logic [7:0] wr_buf [$];
	check_t     chk_q [$];
	event       chk_ev;
	int         n_rd;
	int         n_ack;
	int         err_rd;
	int         err_ack;
	int         err_rst;

	assign sda_bus = sda_m & ~(sda_oe & ~sda_out); // open drain

	i2c_slave_top dut (
		.sys_clk  (sys_clk),
		.rst_n    (rst_n),
		.scl_i    (scl_m),
		.sda_i    (sda_bus),
		.sda_oe_o (sda_oe),
		.sda_o    (sda_out)
	);

	always #50 sys_clk = ~sys_clk;

	`include "i2c_master_tasks.svh"

	// expected register contents
	function automatic logic [7:0] ref_read(input reg_addr_t addr);
		if (addr == 16'h0000)
			return {1'b0, mdl_dev};
		else if (addr >= 16'h0001 && addr <= 16'h0004)
			return 8'(16'h00A0 + addr - 16'h0001);
		else if (addr >= 16'h0005 && addr <= 16'h000C)
			return mdl_rw[3'(addr - 16'h0005)];
		return 8'hFF;
	endfunction

	function automatic void model_write(input reg_addr_t addr, input logic [7:0] data);
		if (addr == 16'h0000)
			mdl_dev = data[6:0];
		else if (addr >= 16'h0005 && addr <= 16'h000C)
			mdl_rw[3'(addr - 16'h0005)] = data;
	endfunction

	task automatic post_check(input logic is_ack, input reg_addr_t addr,
		input logic [7:0] exp, input logic [7:0] got);
		chk_q.push_back('{is_ack, addr, exp, got});
		-> chk_ev;
	endtask

	task automatic send_checked(input logic [7:0] data, input logic hit, input reg_addr_t ctx);
		logic ack;
		logic pulled;
		write_byte(data, ack, pulled);
		post_check(1'b1, ctx, {7'd0, hit}, {7'd0, hit ? ack : pulled});
	endtask

	task automatic reg_write(input logic [6:0] dev, input reg_addr_t addr,
		input logic [7:0] data [$]);
		logic hit;
		hit = (dev == mdl_dev); // decided before a write to register 0
		bus_start();
		send_checked({dev, 1'b0}, hit, addr);
		send_checked(addr[15:8], hit, addr);
		send_checked(addr[7:0], hit, addr);
		foreach (data[i]) begin
			send_checked(data[i], hit, addr + 16'(i));
			if (hit)
				model_write(addr + 16'(i), data[i]);
		end
		bus_stop();
	endtask

	task automatic reg_read(input logic [6:0] dev, input reg_addr_t addr, input int n);
		logic       hit;
		logic [7:0] got;
		hit = (dev == mdl_dev);
		bus_start();
		send_checked({dev, 1'b0}, hit, addr);
		send_checked(addr[15:8], hit, addr);
		send_checked(addr[7:0], hit, addr);
		bus_start();
		send_checked({dev, 1'b1}, hit, addr);
		for (int i = 0; i < n; i++) begin
			read_byte(i == n - 1, got); // NACK ends the read
			if (hit)
				post_check(1'b0, addr + 16'(i), ref_read(addr + 16'(i)), got);
		end
		bus_stop();
	endtask

	always @(chk_ev) begin
		check_t c;
		while (chk_q.size() > 0) begin
			c = chk_q.pop_front();
			if (c.is_ack) begin
				n_ack++;
				a_ack: assert (c.got == c.exp) else begin
					err_ack++;
					$display("ERROR %0t: ACK for reg 0x%04h, expected %0d got %0d",
						$time, c.addr, c.exp[0], c.got[0]);
				end
			end else begin
				n_rd++;
				a_rd: assert (c.got == c.exp) else begin
					err_rd++;
					$display("ERROR %0t: read reg 0x%04h, expected 0x%02h got 0x%02h",
						$time, c.addr, c.exp, c.got);
				end
			end
		end
	end

	initial begin
		reg_addr_t a;
		logic [7:0] d;
		void'($urandom(32'h1038));
		sys_clk = 1'b0;
		rst_n   = 1'b0;
		scl_m   = 1'b1;
		sda_m   = 1'b1;
		n_rd    = 0;
		n_ack   = 0;
		err_rd  = 0;
		err_ack = 0;
		err_rst = 0;
		mdl_dev = 7'h36;
		for (int i = 0; i < 8; i++) begin
			mdl_rw[i] = 8'(8'hB0 + i);
		end
		wait_clks(8);
		rst_n = 1'b1;
		wait_clks(10);

		a_rst: assert (!sda_oe && sda_out) else begin
			err_rst++;
			$display("ERROR %0t: SDA outputs after reset, expected oe 0 o 1 got oe %0b o %0b",
				$time, sda_oe, sda_out);
		end

		reg_read(mdl_dev, 16'h0000, 14); // whole map after reset

		wr_buf = '{8'h11, 8'h22, 8'h33, 8'h44};
		reg_write(mdl_dev, 16'h0007, wr_buf);
		reg_read(mdl_dev, 16'h0005, 8);
		wr_buf = '{8'h5C, 8'h6D};
		reg_write(mdl_dev, 16'h0002, wr_buf); // read-only, ignored
		wr_buf = '{8'h77};
		reg_write(mdl_dev, 16'h0020, wr_buf);
		reg_read(mdl_dev, 16'h0001, 4);
		reg_read(mdl_dev, 16'h0020, 1);

		wr_buf = '{8'h00};
		reg_write(7'h37, 16'h0005, wr_buf); // wrong device
		reg_read(mdl_dev, 16'h0000, 14);

		wr_buf = '{8'h52};
		reg_write(mdl_dev, 16'h0000, wr_buf);
		wr_buf = '{8'h5A};
		reg_write(7'h36, 16'h0006, wr_buf); // old address now NACKs
		reg_read(mdl_dev, 16'h0000, 1);

		for (int k = 0; k < 20; k++) begin
			a = 16'($urandom_range(16, 1)); // never register 0
			d = 8'($urandom);
			wr_buf = '{d};
			reg_write(mdl_dev, a, wr_buf);
			a = 16'($urandom_range(16, 0));
			reg_read(mdl_dev, a, 1);
		end

		wait_clks(2);
		$display("checks: %0d reads, %0d acks; errors: %0d read, %0d ack, %0d reset",
			n_rd, n_ack, err_rd, err_ack, err_rst);
		if (err_rd + err_ack + err_rst == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== hdl/i2c_slave_top.sv ====
//********************
// SDA pad is open drain, pull low when sda_oe_o and not sda_o
// SCL is input only, no clock stretching
//********************
module i2c_slave_top
	import i2c_pkg::*;
	import regmap_pkg::*;
#(
	parameter int SAMPLE_THRESH_CYC = 32, // SDA-high cycles that make a 1
	parameter int STOP_HOLD_CYC     = 50  // idle cycles after STOP
) (
	input  logic sys_clk,
	input  logic rst_n,
	input  logic scl_i,
	input  logic sda_i,
	output logic sda_oe_o,
	output logic sda_o
);

	bus_evt_t   bus_evt;
	reg_req_t   req;
	logic [7:0] rd_data;
	logic [6:0] dev_addr;

	i2c_bus_sampler #(
		.SAMPLE_THRESH_CYC (SAMPLE_THRESH_CYC)
	) u_sampler (
		.sys_clk   (sys_clk),
		.rst_n     (rst_n),
		.scl_i     (scl_i),
		.sda_i     (sda_i),
		.bus_evt_o (bus_evt)
	);

	i2c_slave_ctrl #(
		.STOP_HOLD_CYC (STOP_HOLD_CYC)
	) u_ctrl (
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.bus_evt_i  (bus_evt),
		.dev_addr_i (dev_addr),
		.rd_data_i  (rd_data),
		.req_o      (req),
		.sda_oe_o   (sda_oe_o),
		.sda_o      (sda_o)
	);

	i2c_reg_file u_reg_file (
		.sys_clk    (sys_clk),
		.rst_n      (rst_n),
		.req_i      (req),
		.rd_data_o  (rd_data),
		.dev_addr_o (dev_addr)
	);

endmodule

// ==== hdl/i2c_reg_file.sv ====
//********************
// reads take one cycle, writes land on the strobe edge
// read-only and unmapped writes are dropped silently
//********************
module i2c_reg_file
	import i2c_pkg::*;
	import regmap_pkg::*;
(
	input  logic       sys_clk,
	input  logic       rst_n,
	input  reg_req_t   req_i,
	output logic [7:0] rd_data_o,
	output logic [6:0] dev_addr_o
);

	localparam int RO_IW = $clog2(RO_COUNT);
	localparam int RW_IW = $clog2(RW_COUNT);
	localparam reg_addr_t RO_LAST = RO_BASE + reg_addr_t'(RO_COUNT - 1);
	localparam reg_addr_t RW_LAST = RW_BASE + reg_addr_t'(RW_COUNT - 1);

	logic [6:0]       dev_addr_q;
	logic [7:0]       rw_q [RW_COUNT];
	logic             in_ro;
	logic             in_rw;
	logic [RO_IW-1:0] ro_idx;
	logic [RW_IW-1:0] rw_idx;

	assign in_ro  = (req_i.addr >= RO_BASE) && (req_i.addr <= RO_LAST);
	assign in_rw  = (req_i.addr >= RW_BASE) && (req_i.addr <= RW_LAST);
	assign ro_idx = RO_IW'(req_i.addr - RO_BASE);
	assign rw_idx = RW_IW'(req_i.addr - RW_BASE);

	assign dev_addr_o = dev_addr_q;

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			dev_addr_q <= I2C_DEF_DEV_ADDR;
			for (int i = 0; i < RW_COUNT; i++) begin
				rw_q[i] <= RW_INIT[i];
			end
		end else if (req_i.wr_stb) begin
			if (req_i.addr == REG_DEV_ADDR) begin
				dev_addr_q <= req_i.wdata[6:0]; // new address takes effect next START
			end else if (in_rw) begin
				rw_q[rw_idx] <= req_i.wdata;
			end
		end
	end

	// read mux, held until the next strobe
	always_ff @(posedge sys_clk) begin
		if (req_i.rd_stb) begin
			if (req_i.addr == REG_DEV_ADDR) begin
				rd_data_o <= {1'b0, dev_addr_q};
			end else if (in_ro) begin
				rd_data_o <= RO_INIT[ro_idx]; // fixed read-only contents
			end else if (in_rw) begin
				rd_data_o <= rw_q[rw_idx];
			end else begin
				rd_data_o <= UNMAPPED_DATA;
			end
		end
	end

endmodule

// ==== hdl/i2c_slave_ctrl.sv ====
//********************
// never NACKs a read, the controller ends reads with NACK then STOP
// repeated START restarts address matching only
//********************
module i2c_slave_ctrl
	import i2c_pkg::*;
	import regmap_pkg::*;
#(
	parameter int STOP_HOLD_CYC = 50
) (
	input  logic       sys_clk,
	input  logic       rst_n,
	input  bus_evt_t   bus_evt_i,
	input  logic [6:0] dev_addr_i,
	input  logic [7:0] rd_data_i,
	output reg_req_t   req_o,
	output logic       sda_oe_o,
	output logic       sda_o
);

	localparam int HOLD_W = $clog2(STOP_HOLD_CYC + 1);
	localparam logic [HOLD_W-1:0] HOLD_MAX = HOLD_W'(STOP_HOLD_CYC);

	ctrl_state_t       state_q;
	logic [3:0]        bit_cnt_q;  // 0..7 data bits, 8 is the ACK slot
	logic [6:0]        shift_q;
	reg_addr_t         reg_addr_q;
	logic              rd_pend_q;  // becomes rd_stb
	logic [7:0]        drv_cnt_q;  // countdown to the next SDA drive
	logic [HOLD_W-1:0] hold_cnt_q;
	logic [7:0]        rx_byte;
	logic              in_frame;
	logic              byte_done;
	logic              ack_done;
	logic              addr_match;
	logic              drv_now;
	logic              read_bit;

	assign rx_byte    = {shift_q, bus_evt_i.bit_val};
	assign in_frame   = (state_q != IDLE) && (state_q != WAIT_STOP);
	assign byte_done  = bus_evt_i.bit_valid && (bit_cnt_q == 4'd7);
	assign ack_done   = bus_evt_i.bit_valid && (bit_cnt_q == 4'd8);
	assign addr_match = (rx_byte[7:1] == dev_addr_i);
	assign drv_now    = (drv_cnt_q == 8'd1);
	assign read_bit   = rd_data_i[3'd7 - bit_cnt_q[2:0]]; // MSB first

	always_comb begin
		req_o        = '0;
		req_o.wr_stb = (state_q == WR_DATA) && byte_done; // same cycle as the 8th bit
		req_o.rd_stb = rd_pend_q;
		req_o.addr   = reg_addr_q;
		req_o.wdata  = rx_byte;
	end

	// shift register and address counter
	always_ff @(posedge sys_clk) begin
		if (in_frame && bus_evt_i.bit_valid && bit_cnt_q != 4'd8) begin
			shift_q <= rx_byte[6:0];
		end
		case (state_q)
			REG_ADDR_HI: if (byte_done) reg_addr_q[15:8] <= rx_byte;
			REG_ADDR_LO: if (byte_done) reg_addr_q[7:0] <= rx_byte;
			WR_DATA:     if (ack_done) reg_addr_q <= reg_addr_q + 16'd1;
			RD_DATA: begin
				if (bus_evt_i.scl_rise && bit_cnt_q == 4'd8) begin
					reg_addr_q <= reg_addr_q + 16'd1; // prefetch next byte
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			state_q    <= IDLE;
			bit_cnt_q  <= 4'd0;
			rd_pend_q  <= 1'b0;
			drv_cnt_q  <= 8'd0;
			hold_cnt_q <= '0;
			sda_oe_o   <= 1'b0;
			sda_o      <= 1'b1;
		end else begin
			rd_pend_q <= 1'b0;
			if (drv_cnt_q != 8'd0) begin
				drv_cnt_q <= drv_cnt_q - 8'd1;
			end
			if (bus_evt_i.stop) begin
				state_q    <= WAIT_STOP;
				drv_cnt_q  <= 8'd0;
				hold_cnt_q <= '0;
				sda_oe_o   <= 1'b0;
				sda_o      <= 1'b1;
			end else if (bus_evt_i.start) begin
				state_q   <= DEV_ADDR;
				bit_cnt_q <= 4'd0;
				drv_cnt_q <= 8'd0;
				sda_oe_o  <= 1'b0;
				sda_o     <= 1'b1;
			end else begin
				if (in_frame && bus_evt_i.bit_valid) begin
					bit_cnt_q <= (bit_cnt_q == 4'd8) ? 4'd0 : bit_cnt_q + 4'd1;
				end
				if (drv_now) begin
					sda_oe_o <= 1'b1;
					sda_o    <= (state_q == RD_DATA && bit_cnt_q != 4'd8) ? read_bit : 1'b0;
				end
				case (state_q)
					IDLE: ; // wait for START
					DEV_ADDR: begin
						if (byte_done) begin
							if (addr_match) begin
								drv_cnt_q <= ACK_DELAY_CYC;
								rd_pend_q <= rx_byte[0]; // fetch first read byte
							end else begin
								state_q <= IDLE;
							end
						end else if (ack_done) begin
							sda_oe_o <= 1'b0;
							sda_o    <= 1'b1;
							if (shift_q[0]) begin
								state_q   <= RD_DATA;
								drv_cnt_q <= ACK_DELAY_CYC;
							end else begin
								state_q <= REG_ADDR_HI;
							end
						end
					end
					REG_ADDR_HI, REG_ADDR_LO, WR_DATA: begin
						if (byte_done) begin
							drv_cnt_q <= ACK_DELAY_CYC;
						end else if (ack_done) begin
							sda_oe_o <= 1'b0;
							sda_o    <= 1'b1;
							if (state_q == REG_ADDR_HI) begin
								state_q <= REG_ADDR_LO;
							end else begin
								state_q <= WR_DATA;
							end
						end
					end
					RD_DATA: begin
						if (bus_evt_i.scl_rise && bit_cnt_q == 4'd8) begin
							rd_pend_q <= 1'b1;
						end
						if (byte_done) begin
							sda_oe_o <= 1'b0; // controller drives its ACK
							sda_o    <= 1'b1;
						end else if (ack_done) begin
							if (bus_evt_i.bit_val) begin
								state_q    <= WAIT_STOP; // NACK ends the read
								hold_cnt_q <= '0;
							end else begin
								drv_cnt_q <= ACK_DELAY_CYC;
							end
						end else if (bus_evt_i.bit_valid) begin
							drv_cnt_q <= ACK_DELAY_CYC;
						end
					end
					WAIT_STOP: begin
						if (bus_evt_i.scl_high && bus_evt_i.sda_high) begin
							if (hold_cnt_q == HOLD_MAX) begin
								state_q <= IDLE;
							end else begin
								hold_cnt_q <= hold_cnt_q + 1'b1;
							end
						end else begin
							hold_cnt_q <= '0;
						end
					end
					default: state_q <= IDLE;
				endcase
			end
		end
	end

	a_idle_released: assert property (@(posedge sys_clk) disable iff (!rst_n)
		(state_q == IDLE) |-> !sda_oe_o)
		else $error("ctrl: SDA driven while idle");

	a_one_strobe: assert property (@(posedge sys_clk) disable iff (!rst_n)
		!(req_o.wr_stb && req_o.rd_stb))
		else $error("ctrl: read and write strobe together");

endmodule

// ==== hdl/i2c_bus_sampler.sv ====
//********************
// scl_i and sda_i may be asynchronous, events lag the pins by 3 cycles
// SCL high time must exceed SAMPLE_THRESH_CYC for a 1 to be seen
//********************
module i2c_bus_sampler
	import i2c_pkg::*;
#(
	parameter int SAMPLE_THRESH_CYC = 32
) (
	input  logic     sys_clk,
	input  logic     rst_n,
	input  logic     scl_i,
	input  logic     sda_i,
	output bus_evt_t bus_evt_o
);

	localparam int CNT_W = $clog2(SAMPLE_THRESH_CYC + 1);
	localparam logic [CNT_W-1:0] THRESH = CNT_W'(SAMPLE_THRESH_CYC);

	logic [2:0]       scl_sync_q; // [1:0] synchronizer, [2] edge history
	logic [2:0]       sda_sync_q;
	logic [CNT_W-1:0] high_cnt_q; // SDA-high cycles in this SCL-high period
	logic             in_bit_q;   // SCL rose since last START/STOP
	logic             scl_lvl;
	logic             sda_lvl;
	logic             scl_rise;
	logic             scl_fall;
	logic             sda_rise;
	logic             sda_fall;
	logic             start_det;
	logic             stop_det;

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			scl_sync_q <= 3'b111; // idle bus reads high
			sda_sync_q <= 3'b111;
		end else begin
			scl_sync_q <= {scl_sync_q[1:0], scl_i};
			sda_sync_q <= {sda_sync_q[1:0], sda_i};
		end
	end

	assign scl_lvl   = scl_sync_q[1];
	assign sda_lvl   = sda_sync_q[1];
	assign scl_rise  = scl_lvl & ~scl_sync_q[2];
	assign scl_fall  = ~scl_lvl & scl_sync_q[2];
	assign sda_rise  = sda_lvl & ~sda_sync_q[2];
	assign sda_fall  = ~sda_lvl & sda_sync_q[2];
	assign start_det = sda_fall & scl_lvl & scl_sync_q[2];
	assign stop_det  = sda_rise & scl_lvl & scl_sync_q[2];

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			high_cnt_q <= '0;
			in_bit_q   <= 1'b0;
		end else begin
			if (scl_rise) begin
				high_cnt_q <= '0;
			end else if (scl_lvl && sda_lvl && high_cnt_q != THRESH) begin
				high_cnt_q <= high_cnt_q + 1'b1; // saturates at threshold
			end
			if (start_det || stop_det || scl_fall) begin
				in_bit_q <= 1'b0;
			end else if (scl_rise) begin
				in_bit_q <= 1'b1;
			end
		end
	end

	always_comb begin
		bus_evt_o.scl_rise  = scl_rise;
		bus_evt_o.scl_fall  = scl_fall;
		bus_evt_o.start     = start_det;
		bus_evt_o.stop      = stop_det;
		bus_evt_o.bit_valid = scl_fall & in_bit_q; // no bit for the fall after START
		bus_evt_o.bit_val   = (high_cnt_q >= THRESH);
		bus_evt_o.scl_high  = scl_lvl;
		bus_evt_o.sda_high  = sda_lvl;
	end

	a_start_stop_excl: assert property (@(posedge sys_clk) disable iff (!rst_n)
		!(bus_evt_o.start && bus_evt_o.stop))
		else $error("sampler: START and STOP in one cycle");

endmodule

// ==== hdl/regmap_pkg.sv ====
//********************
// register addresses are always 16 bits wide
// only the low 13 addresses are mapped
//********************
package regmap_pkg;

	typedef logic [15:0] reg_addr_t;

	// register access request from the bus FSM
	typedef struct packed {
		logic      wr_stb; // one-cycle write strobe
		logic      rd_stb; // one-cycle read strobe
		reg_addr_t addr;
		logic [7:0] wdata;
	} reg_req_t;

	localparam reg_addr_t REG_DEV_ADDR = 16'h0000; // bus address, bits 6..0
	localparam reg_addr_t RO_BASE      = 16'h0001;
	localparam reg_addr_t RW_BASE      = 16'h0005;

	localparam int RO_COUNT = 4;
	localparam int RW_COUNT = 8;

	// fixed contents of the read-only block
	localparam logic [7:0] RO_INIT [RO_COUNT] = '{8'hA0, 8'hA1, 8'hA2, 8'hA3};

	// reset contents of the read/write block
	localparam logic [7:0] RW_INIT [RW_COUNT] = '{
		8'hB0, 8'hB1, 8'hB2, 8'hB3,
		8'hB4, 8'hB5, 8'hB6, 8'hB7
	};

	localparam logic [7:0] UNMAPPED_DATA = 8'hFF; // returned for any other address

endpackage

// ==== hdl/i2c_pkg.sv ====
//********************
// bus events are one-cycle strobes in the sys_clk domain
// sys_clk must be much faster than SCL (about 100x)
//********************
package i2c_pkg;

	// one cycle worth of decoded bus activity
	typedef struct packed {
		logic scl_rise;  // synchronized SCL rising edge
		logic scl_fall;  // synchronized SCL falling edge
		logic start;     // SDA fall while SCL high
		logic stop;      // SDA rise while SCL high
		logic bit_valid; // data bit decided, on SCL fall
		logic bit_val;   // decided bit value
		logic scl_high;  // synchronized SCL level
		logic sda_high;  // synchronized SDA level
	} bus_evt_t;

	// target FSM states
	typedef enum logic [2:0] {
		IDLE,
		DEV_ADDR,
		REG_ADDR_HI,
		REG_ADDR_LO,
		WR_DATA,
		RD_DATA,
		WAIT_STOP
	} ctrl_state_t;

	// bus address after reset, changed later through register 0
	localparam logic [6:0] I2C_DEF_DEV_ADDR = 7'h36;

	// cycles from seen SCL fall to SDA update, gives data hold time
	localparam logic [7:0] ACK_DELAY_CYC = 8'd4;

endpackage
